// File: rtl/wire_pkg.sv
//////////////////////////////////////////////////
// wire puzzle package
// colour codes, game states, wire set and buttons
//////////////////////////////////////////////////
`default_nettype none

package wire_pkg;

    // wire slots and colour range
    localparam int unsigned MAX_WIRES  = 6;
    localparam int unsigned MIN_WIRES  = 3;
    localparam int unsigned NUM_COLORS = 5;

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] LFSR_SEED = 16'hACE1;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    // colour code of one wire slot
    typedef enum logic [2:0] {
        RED     = 3'd0,
        WHITE   = 3'd1,
        YELLOW  = 3'd2,
        BLUE    = 3'd3,
        GRAY    = 3'd4,
        NO_WIRE = 3'd5
    } wire_color_t;

    // overall game state from the bomb controller
    typedef enum logic [2:0] {
        GAME_IDLE    = 3'd0,
        GAME_PLAYING = 3'd1,
        GAME_WON     = 3'd2,
        GAME_LOST    = 3'd3
    } game_state_t;

    // which puzzle currently owns the buttons
    typedef enum logic [2:0] {
        PLAY_WIRES   = 3'd0,
        PLAY_BUTTONS = 3'd1,
        PLAY_MEMORY  = 3'd2
    } playing_state_t;

    // wire count plus one colour per slot, slot 0 first
    typedef struct packed {
        logic [2:0]                  wire_num;
        wire_color_t [0:MAX_WIRES-1] colors;
    } wire_set_t;

    // left sits at bit 0
    typedef struct packed {
        logic [2:0] spare;
        logic       cut;
        logic       right;
        logic       left;
    } button_t;

endpackage

`default_nettype wire

// File: rtl/wire_wire_gen.sv
//////////////////////////////////////////////////
// wire set generator
// free-running lfsr, new random set on activate
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wire_wire_gen import wire_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      activate_rand,
    output wire_set_t wire_set
);

    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    wire_set_t   new_set;

    // fold a 3 bit field onto the real colours
    function automatic wire_color_t fold_color(input logic [2:0] field);
        logic [2:0] code;
        code = (field >= 3'(NUM_COLORS)) ? field - 3'(NUM_COLORS) : field;
        return wire_color_t'(code);
    endfunction

    // shift right, apply taps when a one drops out
    assign lfsr_next = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0000);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= lfsr_next;
        end
    end

    // low two bits pick the count, overlapping fields pick colours
    always_comb begin
        new_set.wire_num = 3'(MIN_WIRES) + {1'b0, lfsr[1:0]};
        for (int i = 0; i < MAX_WIRES; i++) begin
            if (3'(i) < new_set.wire_num) begin
                new_set.colors[i] = fold_color(lfsr[2 + 2*i +: 3]);
            end else begin
                new_set.colors[i] = NO_WIRE;
            end
        end
    end

    // set holds until the next activate
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wire_set.wire_num <= '0;
            for (int i = 0; i < MAX_WIRES; i++) begin
                wire_set.colors[i] <= NO_WIRE;
            end
        end else if (activate_rand) begin
            wire_set <= new_set;
        end
    end

endmodule

`default_nettype wire

// File: rtl/wire_wire_locator.sv
//////////////////////////////////////////////////
// wire cursor
// left and right buttons move over present wires
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wire_wire_locator import wire_pkg::*; (
    input  logic           clk,
    input  logic           arst_n,
    input  button_t        button,
    input  logic           strobe,
    input  game_state_t    game_state_in,
    input  playing_state_t playing_state_in,
    input  logic           activate_rand,
    input  logic [2:0]     wire_num,
    output logic [2:0]     wire_pos
);

    logic press_valid;
    logic at_top;

    // press only counts while the wire puzzle is live
    assign press_valid = strobe
                         && (game_state_in == GAME_PLAYING)
                         && (playing_state_in == PLAY_WIRES);

    // cursor already on the last present wire
    assign at_top = ({1'b0, wire_pos} + 4'd1) >= {1'b0, wire_num};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wire_pos <= '0;
        end else if (activate_rand) begin
            wire_pos <= '0;
        end else if (press_valid && button.left) begin
            // left wins over right
            if (wire_pos != 3'd0) begin
                wire_pos <= wire_pos - 3'd1;
            end
        end else if (press_valid && button.right) begin
            if (!at_top) begin
                wire_pos <= wire_pos + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/wire_rule_solver.sv
//////////////////////////////////////////////////
// wire rule solver
// colour rules giving the slot that must be cut
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wire_rule_solver import wire_pkg::*; (
    input  wire_set_t  wire_set,
    output logic [2:0] solution
);

    logic [2:0]  red_cnt;
    logic [2:0]  white_cnt;
    logic [2:0]  yellow_cnt;
    logic [2:0]  blue_cnt;
    logic [2:0]  gray_cnt;
    logic [2:0]  last_red;
    logic [2:0]  last_blue;
    wire_color_t last_color;

    // colour counts over present slots only
    always_comb begin
        red_cnt    = '0;
        white_cnt  = '0;
        yellow_cnt = '0;
        blue_cnt   = '0;
        gray_cnt   = '0;
        last_red   = '0;
        last_blue  = '0;
        last_color = NO_WIRE;
        for (int i = 0; i < MAX_WIRES; i++) begin
            if (3'(i) < wire_set.wire_num) begin
                last_color = wire_set.colors[i];
                case (wire_set.colors[i])
                    RED: begin
                        red_cnt  = red_cnt + 3'd1;
                        last_red = 3'(i);
                    end
                    WHITE:  white_cnt  = white_cnt + 3'd1;
                    YELLOW: yellow_cnt = yellow_cnt + 3'd1;
                    BLUE: begin
                        blue_cnt  = blue_cnt + 3'd1;
                        last_blue = 3'(i);
                    end
                    GRAY:   gray_cnt = gray_cnt + 3'd1;
                    default: ;
                endcase
            end
        end
    end

    // first matching rule wins; indices are zero based
    always_comb begin
        case (wire_set.wire_num)
            3'd3: begin
                if (red_cnt == 3'd0)
                    solution = 3'd1;
                else if (last_color == WHITE)
                    solution = 3'd2;
                else if (blue_cnt > 3'd1)
                    solution = last_blue;
                else
                    solution = 3'd2;
            end
            3'd4: begin
                if (red_cnt > 3'd1)
                    solution = last_red;
                else if (last_color == YELLOW && red_cnt == 3'd0)
                    solution = 3'd0;
                else if (blue_cnt == 3'd1)
                    solution = 3'd0;
                else if (yellow_cnt > 3'd1)
                    solution = 3'd3;
                else
                    solution = 3'd1;
            end
            3'd5: begin
                if (last_color == GRAY)
                    solution = 3'd3;
                else if (red_cnt == 3'd1 && yellow_cnt > 3'd1)
                    solution = 3'd0;
                else if (gray_cnt == 3'd0)
                    solution = 3'd1;
                else
                    solution = 3'd0;
            end
            3'd6: begin
                if (yellow_cnt == 3'd0)
                    solution = 3'd2;
                else if (yellow_cnt == 3'd1 && white_cnt > 3'd1)
                    solution = 3'd3;
                else if (red_cnt == 3'd0)
                    solution = 3'd5;
                else
                    solution = 3'd3;
            end
            // no set loaded yet
            default: solution = 3'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/wire_cut_detector.sv
//////////////////////////////////////////////////
// wire cut detector
// cut status, clear level and one-cycle error
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wire_cut_detector import wire_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  button_t              button,
    input  logic                 strobe,
    input  game_state_t          game_state_in,
    input  playing_state_t       playing_state_in,
    input  logic                 activate_rand,
    input  wire_set_t            wire_set,
    input  logic [2:0]           wire_pos,
    output logic [MAX_WIRES-1:0] wire_status,
    output logic                 wire_clear,
    output logic                 wire_error
);

    logic       press_valid;
    logic       pos_present;
    logic       cut_valid;
    logic [2:0] solution;

    wire_rule_solver wire_rule_solver_0 (
        .wire_set (wire_set),
        .solution (solution)
    );

    assign press_valid = strobe
                         && (game_state_in == GAME_PLAYING)
                         && (playing_state_in == PLAY_WIRES);

    assign pos_present = wire_pos < wire_set.wire_num;

    // slot must exist, be uncut, and the puzzle must not be solved
    assign cut_valid = press_valid && button.cut && pos_present
                       && !wire_status[wire_pos] && !wire_clear;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wire_status <= '0;
            wire_clear  <= 1'b0;
            wire_error  <= 1'b0;
        end else if (activate_rand) begin
            wire_status <= '0;
            wire_clear  <= 1'b0;
            wire_error  <= 1'b0;
        end else begin
            // error is a pulse, so it drops unless a wrong cut lands now
            wire_error <= 1'b0;
            if (cut_valid) begin
                wire_status[wire_pos] <= 1'b1;
                if (wire_pos == solution) begin
                    wire_clear <= 1'b1;
                end else begin
                    wire_error <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/wire_game.sv
//////////////////////////////////////////////////
// wire puzzle top
// generator, cursor and cut detector
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wire_game import wire_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  button_t              button,
    input  logic                 strobe,
    input  game_state_t          game_state_in,
    input  playing_state_t       playing_state_in,
    input  logic                 activate_rand,
    output wire_set_t            wire_set,
    output logic [2:0]           wire_pos,
    output logic [MAX_WIRES-1:0] wire_status,
    output logic                 wire_clear,
    output logic                 wire_error
);

    wire_wire_gen wire_wire_gen_0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .activate_rand (activate_rand),
        .wire_set      (wire_set)
    );

    wire_wire_locator wire_locator_0 (
        .clk              (clk),
        .arst_n           (arst_n),
        .button           (button),
        .strobe           (strobe),
        .game_state_in    (game_state_in),
        .playing_state_in (playing_state_in),
        .activate_rand    (activate_rand),
        .wire_num         (wire_set.wire_num),
        .wire_pos         (wire_pos)
    );

    wire_cut_detector wire_cut_detector_0 (
        .clk              (clk),
        .arst_n           (arst_n),
        .button           (button),
        .strobe           (strobe),
        .game_state_in    (game_state_in),
        .playing_state_in (playing_state_in),
        .activate_rand    (activate_rand),
        .wire_set         (wire_set),
        .wire_pos         (wire_pos),
        .wire_status      (wire_status),
        .wire_clear       (wire_clear),
        .wire_error       (wire_error)
    );

endmodule

`default_nettype wire

// File: test/wire_rules_model.svh
//////////////////////////////////////////////////
// wire puzzle reference model
// expected cut index and cursor step
//////////////////////////////////////////////////
`ifndef WIRE_RULES_MODEL_SVH
`define WIRE_RULES_MODEL_SVH

// slot the colour rules say to cut, first matching rule wins
function automatic logic [2:0] solve_rules(input wire_set_t ws);
    int          n;
    int          reds;
    int          whites;
    int          yellows;
    int          blues;
    int          grays;
    int          last_red;
    int          last_blue;
    int          idx;
    wire_color_t last;
    n         = int'(ws.wire_num);
    reds      = 0;
    whites    = 0;
    yellows   = 0;
    blues     = 0;
    grays     = 0;
    last_red  = 0;
    last_blue = 0;
    last      = NO_WIRE;
    for (int i = 0; i < n; i++) begin
        last = ws.colors[i];
        if (last == RED) begin
            reds++;
            last_red = i;
        end
        if (last == BLUE) begin
            blues++;
            last_blue = i;
        end
        whites  += int'(last == WHITE);
        yellows += int'(last == YELLOW);
        grays   += int'(last == GRAY);
    end
    // ordinals count from slot 0, so the second wire is index 1
    case (n)
        3: idx = (reds == 0)                   ? 1 :
                 (last == WHITE)               ? n - 1 :
                 (blues > 1)                   ? last_blue : n - 1;
        4: idx = (reds > 1)                    ? last_red :
                 (last == YELLOW && reds == 0) ? 0 :
                 (blues == 1)                  ? 0 :
                 (yellows > 1)                 ? n - 1 : 1;
        5: idx = (last == GRAY)                ? 3 :
                 (reds == 1 && yellows > 1)    ? 0 :
                 (grays == 0)                  ? 1 : 0;
        6: idx = (yellows == 0)                ? 2 :
                 (yellows == 1 && whites > 1)  ? 3 :
                 (reds == 0)                   ? n - 1 : 3;
        default: idx = 0;
    endcase
    return 3'(idx);
endfunction

// cursor after one press, left wins, saturating on the present wires
function automatic logic [2:0] step_cursor(input logic [2:0] pos, input logic [2:0] num,
                                           input logic go_left, input logic go_right);
    int p;
    p = int'(pos);
    if (go_left) begin
        p = (p > 0) ? p - 1 : 0;
    end else if (go_right) begin
        p = (p + 1 < int'(num)) ? p + 1 : p;
    end
    return 3'(p);
endfunction

`endif

// File: test/tb_wire_game.sv
//////////////////////////////////////////////////
// wire puzzle testbench
// directed tests checked against the rules model
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_wire_game import wire_pkg::*; ();

    localparam int CLK_PERIOD_NS = 4;
    localparam int NUM_TESTS     = 5;
    localparam int TEST_CYCLES   = 4000;
    localparam int WATCHDOG_NS   = NUM_TESTS * TEST_CYCLES * CLK_PERIOD_NS + 1000;

    logic                 clk;
    logic                 arst_n;
    button_t              button;
    logic                 strobe;
    game_state_t          game_state_in;
    playing_state_t       playing_state_in;
    logic                 activate_rand;
    wire_set_t            wire_set;
    logic [2:0]           wire_pos;
    logic [MAX_WIRES-1:0] wire_status;
    logic                 wire_clear;
    logic                 wire_error;

    integer               seed;
    int                   error_count;
    int                   check_count;
    int                   tests_failed;
    logic [2:0]           exp_pos;
    logic [MAX_WIRES-1:0] exp_status;

    `include "wire_rules_model.svh"

    wire_game dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns before all tests finished", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("mismatch at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // one strobed press, returns at the falling edge after it lands
    task automatic press(input logic go_left, input logic go_right, input logic go_cut);
        @(posedge clk);
        button <= {3'd0, go_cut, go_right, go_left};
        strobe <= 1'b1;
        @(posedge clk);
        button <= '0;
        strobe <= 1'b0;
        @(negedge clk);
    endtask

    task automatic step_and_check(input logic go_left, input logic go_right);
        press(go_left, go_right, 1'b0);
        exp_pos = step_cursor(exp_pos, wire_set.wire_num, go_left, go_right);
        check_value(32'(wire_pos), 32'(exp_pos), "cursor after move");
    endtask

    task automatic move_cursor_to(input logic [2:0] target);
        while (exp_pos != target) begin
            step_and_check(exp_pos > target, exp_pos < target);
        end
    endtask

    task automatic cut_and_check(input logic exp_clear, input logic exp_error);
        press(1'b0, 1'b0, 1'b1);
        check_value(32'(wire_status), 32'(exp_status), "status after cut");
        check_value(32'(wire_clear), 32'(exp_clear), "clear after cut");
        check_value(32'(wire_error), 32'(exp_error), "error after cut");
    endtask

    // random idle gap, then one activate pulse
    task automatic arm_new_set();
        int idle;
        idle = $unsigned($random(seed)) % 8;
        repeat (idle) @(posedge clk);
        @(posedge clk);
        activate_rand <= 1'b1;
        @(posedge clk);
        activate_rand <= 1'b0;
        @(negedge clk);
        exp_pos    = 3'd0;
        exp_status = '0;
        check_value(32'(wire_pos), 0, "cursor after activate");
        check_value(32'(wire_status), 0, "status after activate");
        check_value(32'(wire_clear), 0, "clear after activate");
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("test %s ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s failed with %0d mismatches", name, error_count - errs_before);
        end
    endtask

    task automatic reset_and_generation();
        int errs;
        errs = error_count;
        check_value(32'(wire_set.wire_num), 0, "wire count after reset");
        for (int i = 0; i < MAX_WIRES; i++) begin
            check_value(32'(wire_set.colors[i]), 32'(NO_WIRE), "colour after reset");
        end
        check_value(32'(wire_pos), 0, "cursor after reset");
        check_value(32'(wire_status), 0, "status after reset");
        check_value(32'(wire_clear), 0, "clear after reset");
        check_value(32'(wire_error), 0, "error after reset");
        repeat (40) begin
            arm_new_set();
            check_value(32'(wire_set.wire_num >= 3'd3 && wire_set.wire_num <= 3'd6), 1,
                        "wire count in range");
            for (int i = 0; i < MAX_WIRES; i++) begin
                if (3'(i) < wire_set.wire_num) begin
                    check_value(32'(wire_set.colors[i] <= GRAY), 1, "present slot colour");
                end else begin
                    check_value(32'(wire_set.colors[i]), 32'(NO_WIRE), "absent slot colour");
                end
            end
        end
        report_test("reset_and_generation", errs);
    endtask

    task automatic ignored_press(input game_state_t gs, input playing_state_t ps);
        @(posedge clk);
        game_state_in    <= gs;
        playing_state_in <= ps;
        press(1'b0, 1'b1, 1'b1);
        check_value(32'(wire_pos), 32'(exp_pos), "cursor with puzzle inactive");
        check_value(32'(wire_status), 0, "status with puzzle inactive");
    endtask

    task automatic cursor_moves();
        int errs;
        errs = error_count;
        arm_new_set();
        step_and_check(1'b1, 1'b0);
        repeat (int'(wire_set.wire_num) + 1) step_and_check(1'b0, 1'b1);
        step_and_check(1'b1, 1'b1);
        repeat (int'(wire_set.wire_num) + 1) step_and_check(1'b1, 1'b0);
        ignored_press(GAME_IDLE, PLAY_WIRES);
        ignored_press(GAME_WON, PLAY_WIRES);
        ignored_press(GAME_LOST, PLAY_WIRES);
        ignored_press(GAME_PLAYING, PLAY_BUTTONS);
        ignored_press(GAME_PLAYING, PLAY_MEMORY);
        @(posedge clk);
        game_state_in    <= GAME_PLAYING;
        playing_state_in <= PLAY_WIRES;
        report_test("cursor_moves", errs);
    endtask

    task automatic correct_cut();
        int         errs;
        logic [2:0] sol;
        errs = error_count;
        repeat (40) begin
            arm_new_set();
            sol = solve_rules(wire_set);
            move_cursor_to(sol);
            exp_status[sol] = 1'b1;
            cut_and_check(1'b1, 1'b0);
            // once solved, a neighbour cut is ignored
            step_and_check(sol != 3'd0, sol == 3'd0);
            cut_and_check(1'b1, 1'b0);
        end
        report_test("correct_cut", errs);
    endtask

    task automatic wrong_cut();
        int         errs;
        logic [2:0] sol;
        errs = error_count;
        repeat (10) begin
            arm_new_set();
            sol = solve_rules(wire_set);
            for (int s = 0; s < int'(wire_set.wire_num); s++) begin
                if (3'(s) != sol) begin
                    move_cursor_to(3'(s));
                    exp_status[s] = 1'b1;
                    cut_and_check(1'b0, 1'b1);
                    @(negedge clk);
                    check_value(32'(wire_error), 0, "error pulse longer than one cycle");
                    // same slot a second time
                    cut_and_check(1'b0, 1'b0);
                end
            end
        end
        report_test("wrong_cut", errs);
    endtask

    task automatic rearm_clears();
        int errs;
        errs = error_count;
        repeat (4) begin
            arm_new_set();
            move_cursor_to(solve_rules(wire_set));
            exp_status[exp_pos] = 1'b1;
            cut_and_check(1'b1, 1'b0);
            if (exp_pos == 3'd0) begin
                step_and_check(1'b0, 1'b1);
            end
            arm_new_set();
        end
        report_test("rearm_clears", errs);
    endtask

    initial begin
        seed              = 1674;
        error_count       = 0;
        check_count       = 0;
        tests_failed      = 0;
        exp_pos           = '0;
        exp_status        = '0;
        arst_n           <= 1'b0;
        button           <= '0;
        strobe           <= 1'b0;
        game_state_in    <= GAME_PLAYING;
        playing_state_in <= PLAY_WIRES;
        activate_rand    <= 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        reset_and_generation();
        cursor_moves();
        correct_cut();
        wrong_cut();
        rearm_clears();
        $display("summary: %0d of %0d tests failed, %0d checks, %0d mismatches",
                 tests_failed, NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wire_game.f
+incdir+test
rtl/wire_pkg.sv
rtl/wire_wire_gen.sv
rtl/wire_wire_locator.sv
rtl/wire_rule_solver.sv
rtl/wire_cut_detector.sv
rtl/wire_game.sv
test/tb_wire_game.sv

// File: run_sim.sh
#!/bin/sh
# build the wire puzzle testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f wire_game.f --top-module tb_wire_game -o tb_wire_game
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_wire_game)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
